// ==== all.f ====
xt_timing_pkg.sv
rate_strobe_gen.sv
cen_generator.sv
reset_sequencer.sv
cpu_run_control.sv
xt_timing_top.sv
tb_xt_timing.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_xt_timing -f all.f \
	-o tb_xt_timing \
	&& ./obj_dir/tb_xt_timing | tee /dev/stderr | grep -q "^TB PASSED$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== tb_xt_timing.sv ====
`timescale 1ns/1ps

module tb_xt_timing
	import xt_timing_pkg::*;
();

	// DUT parameters with short reset and splash for simulation
	localparam int unsigned CLK_HZ           = 50000000;
	localparam int unsigned SYS_RESET_CYCLES = 20;
	localparam int unsigned SPLASH_CYCLES    = 300;
	localparam int unsigned CPU_RESET_DELAY  = 42;

	// Test lengths in clock edges
	localparam int AUDIO_EDGES  = 3000;
	localparam int WINDOW_EDGES = 500;
	localparam int SKIP_EDGE    = 30;
	localparam int NUM_CHANGES  = 6;
	// Whole sequence needs about 7500 cycles
	localparam int CYCLE_LIMIT  = 20000;

	logic       CLK_50M;
	logic       reset_wire;
	cpu_speed_t speed_sel;
	logic       bus_done;
	logic       skip_splash;
	logic       audio_cen;
	logic       cpu_cen;
	logic       turbo;
	logic       sys_reset;
	logic       splash_active;
	logic       cpu_reset;

	logic [15:0] lfsr_state   = 16'd34044;
	int          cycle_count  = 0;
	int          check_count  = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	// Pending checks from stimulus to the compare process
	string       chk_name[$];
	logic [63:0] chk_exp[$];
	logic [63:0] chk_act[$];

	// All DUT ports match TB signal names
	xt_timing_top #(
		.CLK_HZ           (CLK_HZ),
		.SYS_RESET_CYCLES (SYS_RESET_CYCLES),
		.SPLASH_CYCLES    (SPLASH_CYCLES),
		.CPU_RESET_DELAY  (CPU_RESET_DELAY)
	) i_dut (.*);

	// 20 ns clock
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	////////////////////
	// Helpers
	////////////////////

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = (v << 1) | lfsr_state[0];
		end
	endtask

	// Strobe count k edges after a clear is floor(k * rate / CLK_HZ)
	function automatic longint expected_strobes(input longint rate, input longint edges);
		return (edges * rate) / CLK_HZ;
	endfunction

	// Nominal CPU rate per latched speed
	function automatic longint speed_rate(input logic [1:0] code);
		case (code)
			2'd1:    return RATE_7_16_HZ;
			2'd2:    return RATE_14_32_HZ;
			default: return RATE_4_77_HZ;
		endcase
	endfunction

	// Unused code 3 runs as 4.77 MHz
	function automatic logic [1:0] fold_code(input logic [1:0] c);
		return (c == 2'd3) ? 2'd0 : c;
	endfunction

	function automatic logic [1:0] next_speed(input logic [1:0] c);
		return (c == 2'd2) ? 2'd0 : c + 2'd1;
	endfunction

	task automatic post_check(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		chk_name.push_back(name);
		chk_exp.push_back(exp_v);
		chk_act.push_back(act_v);
	endtask

	// Level outputs n edges after reset_wire falls
	task automatic check_reset_outputs(input int n, input int splash_edge);
		post_check("sys_reset", n < SYS_RESET_CYCLES, sys_reset);
		post_check("splash_active", n < splash_edge, splash_active);
		post_check("cpu_reset", n < splash_edge + CPU_RESET_DELAY, cpu_reset);
		post_check("turbo", 0, turbo);
		// CPU enable stays quiet while held
		if (n < splash_edge + CPU_RESET_DELAY) begin
			post_check("cpu_cen", 0, cpu_cen);
		end
	endtask

	// Ends at the negedge after the releasing edge
	task automatic apply_reset();
		@(posedge CLK_50M);
		reset_wire <= 1'b1;
		repeat (5) @(posedge CLK_50M);
		reset_wire <= 1'b0;
		@(negedge CLK_50M);
	endtask

	// One-cycle bus_done with a new speed
	// Returns at the negedge after the latching edge
	task automatic apply_speed(input logic [1:0] code);
		@(posedge CLK_50M);
		speed_sel <= cpu_speed_t'(code);
		bus_done  <= 1'b1;
		@(posedge CLK_50M);
		bus_done  <= 1'b0;
		@(negedge CLK_50M);
	endtask

	// Count cpu_cen per edge
	// speed_sel may move mid-window without bus_done
	task automatic count_cpu(input int edges, input int change_at, input logic [1:0] code,
		output longint cnt);
		cnt = 0;
		for (int k = 0; k < edges; k++) begin
			@(posedge CLK_50M);
			if (k == change_at) begin
				speed_sel <= cpu_speed_t'(code);
			end
			@(negedge CLK_50M);
			cnt += cpu_cen;
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial begin : stimulus
		int unsigned gap;
		int unsigned code;
		logic [1:0]  cur;
		longint      cnt;
		longint      audio_cnt;

		reset_wire  = 1'b1;
		speed_sel   = SPEED_4_77;
		bus_done    = 1'b0;
		skip_splash = 1'b0;

		// First run through stretch, splash and CPU delay while counting audio strobes
		apply_reset();
		audio_cnt = 0;
		for (int n = 1; n <= AUDIO_EDGES; n++) begin
			@(posedge CLK_50M);
			@(negedge CLK_50M);
			audio_cnt += audio_cen;
			check_reset_outputs(n, SYS_RESET_CYCLES + SPLASH_CYCLES);
		end
		post_check("audio_cen count", expected_strobes(RATE_AUDIO_HZ, AUDIO_EDGES), audio_cnt);

		// Latch a turbo speed that the next reset has to clear
		apply_speed(2'd2);
		post_check("turbo", 1, turbo);

		// Second run where skip_splash cuts the splash short
		apply_reset();
		cur = 2'd0;
		for (int n = 1; n <= SKIP_EDGE + CPU_RESET_DELAY + 2; n++) begin
			@(posedge CLK_50M);
			if (n == SKIP_EDGE) begin
				skip_splash <= 1'b1;
			end
			@(negedge CLK_50M);
			check_reset_outputs(n, SKIP_EDGE + 1);
		end
		@(posedge CLK_50M);
		skip_splash <= 1'b0;
		@(negedge CLK_50M);

		// Each random speed change restarts the CPU phase
		for (int i = 0; i < NUM_CHANGES; i++) begin
			take_bits(3, gap);
			take_bits(2, code);
			if (fold_code(code[1:0]) == cur) begin
				code = next_speed(cur);
			end
			repeat (gap) @(negedge CLK_50M);
			apply_speed(code[1:0]);
			cur = fold_code(code[1:0]);
			post_check("turbo", cur != 2'd0, turbo);
			count_cpu(WINDOW_EDGES, -1, 2'd0, cnt);
			post_check("cpu_cen count", expected_strobes(speed_rate(cur), WINDOW_EDGES), cnt);
		end

		// Rate holds while speed_sel moves without bus_done
		cur = next_speed(cur);
		apply_speed(cur);
		count_cpu(2 * WINDOW_EDGES, WINDOW_EDGES / 2, next_speed(cur), cnt);
		post_check("turbo", cur != 2'd0, turbo);
		post_check("cpu_cen count", expected_strobes(speed_rate(cur), 2 * WINDOW_EDGES), cnt);

		// Let the compare process drain
		repeat (2) @(negedge CLK_50M);
		if (chk_name.size() != 0) begin
			$display("Some checks were never compared before the end of the run");
			other_errors++;
		end
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			check_count, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	////////////////////
	// Compare and watchdog
	////////////////////

	always @(negedge CLK_50M) begin : compare
		string       name;
		logic [63:0] exp_v;
		logic [63:0] act_v;

		while (chk_name.size() > 0) begin
			name  = chk_name.pop_front();
			exp_v = chk_exp.pop_front();
			act_v = chk_act.pop_front();
			check_count++;
			if (act_v !== exp_v) begin
				value_errors++;
				$display("Fail %s: expected 0x%0h, actual 0x%0h at %0t",
					name, exp_v, act_v, $time);
			end
		end
	end

	// Hard stop if the sequence stalls
	always @(posedge CLK_50M) begin : watchdog
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks: %0d, value errors: %0d, other errors: %0d",
				check_count, value_errors, other_errors + 1);
			$display("TB FAILED");
			$finish;
		end
	end

endmodule

// ==== xt_timing_top.sv ====
`timescale 1ns/1ps

module xt_timing_top
	import xt_timing_pkg::*;
#(
	parameter int unsigned CLK_HZ           = 50000000,
	parameter int unsigned SYS_RESET_CYCLES = 65535,
	parameter int unsigned SPLASH_CYCLES    = 250000000,
	parameter int unsigned CPU_RESET_DELAY  = 42
) (
	input  logic       CLK_50M,
	input  logic       reset_wire,
	input  cpu_speed_t speed_sel,
	input  logic       bus_done,
	input  logic       skip_splash,
	output logic       audio_cen,
	output logic       cpu_cen,
	output logic       turbo,
	output logic       sys_reset,
	output logic       splash_active,
	output logic       cpu_reset
);

	// Raw CPU strobe before reset gating
	logic cpu_tick;

	// Audio and CPU strobes, speed latch
	cen_generator #(
		.CLK_HZ (CLK_HZ)
	) i_cen_generator (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.speed_sel  (speed_sel),
		.bus_done   (bus_done),
		.audio_cen  (audio_cen),
		.cpu_tick   (cpu_tick),
		.turbo      (turbo)
	);

	// Reset stretch and splash hold
	reset_sequencer #(
		.SYS_RESET_CYCLES (SYS_RESET_CYCLES),
		.SPLASH_CYCLES    (SPLASH_CYCLES)
	) i_reset_sequencer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.skip_splash   (skip_splash),
		.sys_reset     (sys_reset),
		.splash_active (splash_active)
	);

	// CPU release and enable gating
	cpu_run_control #(
		.CPU_RESET_DELAY (CPU_RESET_DELAY)
	) i_cpu_run_control (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.sys_reset     (sys_reset),
		.splash_active (splash_active),
		.cpu_tick      (cpu_tick),
		.cpu_reset     (cpu_reset),
		.cpu_cen       (cpu_cen)
	);

endmodule

// ==== cpu_run_control.sv ====
`timescale 1ns/1ps

module cpu_run_control
	import xt_timing_pkg::*;
#(
	parameter int unsigned CPU_RESET_DELAY = 42
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic sys_reset,
	input  logic splash_active,
	input  logic cpu_tick,
	output logic cpu_reset,
	output logic cpu_cen
);

	// Final value of the delay count
	localparam logic [CNT_WIDTH-1:0] DELAY_LAST = CNT_WIDTH'(CPU_RESET_DELAY - 1);

	logic [CNT_WIDTH-1:0] delay_cnt;
	logic                 hold_cpu;

	// CPU waits for both the stretch and the splash screen
	assign hold_cpu = sys_reset || splash_active;

	////////////////////
	// CPU reset delay
	////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset <= 1'b1;
			delay_cnt <= '0;
		end else if (hold_cpu) begin
			// Keep the delay from starting early
			cpu_reset <= 1'b1;
			delay_cnt <= '0;
		end else if (cpu_reset) begin
			if (delay_cnt == DELAY_LAST) begin
				cpu_reset <= 1'b0;
			end else begin
				delay_cnt <= delay_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// Clock enable gate
	////////////////////

	// No strobes reach the CPU while it sits in reset
	assign cpu_cen = cpu_tick && !cpu_reset;

endmodule

// ==== reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer
	import xt_timing_pkg::*;
#(
	parameter int unsigned SYS_RESET_CYCLES = 65535,
	parameter int unsigned SPLASH_CYCLES    = 250000000
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic skip_splash,
	output logic sys_reset,
	output logic splash_active
);

	// Last count value of each phase
	localparam logic [CNT_WIDTH-1:0] STRETCH_LAST = CNT_WIDTH'(SYS_RESET_CYCLES - 1);
	localparam logic [CNT_WIDTH-1:0] SPLASH_LAST  = CNT_WIDTH'(SPLASH_CYCLES - 1);

	// Edge counters for both phases
	logic [CNT_WIDTH-1:0] stretch_cnt;
	logic [CNT_WIDTH-1:0] splash_cnt;
	logic                 stretch_done;
	logic                 splash_done;

	assign stretch_done = (stretch_cnt == STRETCH_LAST);
	assign splash_done  = (splash_cnt == SPLASH_LAST);

	////////////////////
	// System reset stretch
	////////////////////

	// Holds sys_reset for a fixed number of edges after reset_wire
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset   <= 1'b1;
			stretch_cnt <= '0;
		end else if (sys_reset) begin
			if (stretch_done) begin
				// Stretch over, counter parks here
				sys_reset <= 1'b0;
			end else begin
				stretch_cnt <= stretch_cnt + 1'b1;
			end
		end
	end

	////////////////////
	// Splash screen hold
	////////////////////

	// Starts counting once sys_reset is low
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			splash_cnt    <= '0;
		end else if (splash_active && !sys_reset) begin
			if (skip_splash) begin
				// User asked to skip the logo
				splash_active <= 1'b0;
			end else if (splash_done) begin
				// Full hold time elapsed
				splash_active <= 1'b0;
			end else begin
				splash_cnt <= splash_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== cen_generator.sv ====
`timescale 1ns/1ps

module cen_generator
	import xt_timing_pkg::*;
#(
	parameter int unsigned CLK_HZ = 50000000
) (
	input  logic       CLK_50M,
	input  logic       reset_wire,
	input  cpu_speed_t speed_sel,
	input  logic       bus_done,
	output logic       audio_cen,
	output logic       cpu_tick,
	output logic       turbo
);

	// Latched speed, only follows speed_sel at end of a bus cycle
	cpu_speed_t           speed_q;
	cpu_speed_t           speed_req;
	logic                 speed_change;
	logic [ACC_WIDTH-1:0] cpu_rate;

	////////////////////
	// Speed and turbo latch
	////////////////////

	// Fold the unused code onto the slow speed
	assign speed_req = (speed_sel == SPEED_7_16 || speed_sel == SPEED_14_32) ?
		speed_sel : SPEED_4_77;

	// Update only when the bus cycle ends with a new speed
	assign speed_change = bus_done && (speed_req != speed_q);

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			speed_q <= SPEED_4_77;
		end else if (speed_change) begin
			speed_q <= speed_req;
		end
	end

	// Turbo for anything faster than stock XT
	assign turbo = (speed_q != SPEED_4_77);

	// Rate lookup for the latched speed
	always_comb begin
		case (speed_q)
			SPEED_7_16:  cpu_rate = ACC_WIDTH'(RATE_7_16_HZ);
			SPEED_14_32: cpu_rate = ACC_WIDTH'(RATE_14_32_HZ);
			default:     cpu_rate = ACC_WIDTH'(RATE_4_77_HZ);
		endcase
	end

	////////////////////
	// Strobe generators
	////////////////////

	// Audio sample strobe, free running
	rate_strobe_gen #(
		.CLK_HZ (CLK_HZ)
	) i_audio_strobe (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.clear      (1'b0),
		.rate       (ACC_WIDTH'(RATE_AUDIO_HZ)),
		.strobe     (audio_cen)
	);

	// CPU strobe, phase restarts on a speed change
	rate_strobe_gen #(
		.CLK_HZ (CLK_HZ)
	) i_cpu_strobe (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.clear      (speed_change),
		.rate       (cpu_rate),
		.strobe     (cpu_tick)
	);

endmodule

// ==== rate_strobe_gen.sv ====
`timescale 1ns/1ps

module rate_strobe_gen
	import xt_timing_pkg::*;
#(
	parameter int unsigned CLK_HZ = 50000000
) (
	input  logic                 CLK_50M,
	input  logic                 reset_wire,
	input  logic                 clear,
	input  logic [ACC_WIDTH-1:0] rate,
	output logic                 strobe
);

	// Wrap point of the phase accumulator
	localparam logic [ACC_WIDTH-1:0] ACC_LIMIT = ACC_WIDTH'(CLK_HZ);

	// Phase accumulator, holds the fraction of a strobe period
	logic [ACC_WIDTH-1:0] acc;
	logic [ACC_WIDTH-1:0] acc_sum;
	logic                 acc_wrap;

	// Next phase before wrapping
	assign acc_sum  = acc + rate;
	assign acc_wrap = (acc_sum >= ACC_LIMIT);

	////////////////////
	// Accumulate and wrap
	////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc    <= '0;
			strobe <= 1'b0;
		end else if (clear) begin
			// Restart phase, no strobe this cycle
			acc    <= '0;
			strobe <= 1'b0;
		end else if (acc_wrap) begin
			// One full period reached
			acc    <= acc_sum - ACC_LIMIT;
			strobe <= 1'b1;
		end else begin
			acc    <= acc_sum;
			strobe <= 1'b0;
		end
	end

endmodule

// ==== xt_timing_pkg.sv ====
package xt_timing_pkg;

	////////////////////
	// CPU speed code
	////////////////////

	// Code 3 is unused and treated as the 4.77 MHz speed
	typedef enum logic [1:0] {
		SPEED_4_77  = 2'd0,
		SPEED_7_16  = 2'd1,
		SPEED_14_32 = 2'd2
	} cpu_speed_t;

	////////////////////
	// Strobe rates
	////////////////////

	// Phase accumulator width, wide enough for two clock periods
	localparam int unsigned ACC_WIDTH = 32;

	// Audio sample rate
	localparam int unsigned RATE_AUDIO_HZ = 44100;

	// CPU rates, 14.318 MHz divided by 3, 2 and 1
	localparam int unsigned RATE_4_77_HZ  = 4772727;
	localparam int unsigned RATE_7_16_HZ  = 7159090;
	localparam int unsigned RATE_14_32_HZ = 14318180;

	////////////////////
	// Reset timing
	////////////////////

	// Width of the stretch, splash and delay counters
	localparam int unsigned CNT_WIDTH = 32;

endpackage
